// File: common/soc_defs.svh
`ifndef SOC_DEFS_SVH
`define SOC_DEFS_SVH

// data RAM window
// size counted in 32-bit words
`define RAM_BASE    64'h0000_0000_0000_1000
`define RAM_WORDS   1024

// single-address peripheral registers
`define KEY_ADDR    64'h0000_0000_0000_8000
`define UART_ADDR   64'h0000_0000_0000_8008
`define SDC_ADDR    64'h0000_0000_0000_8010
`define SDC_READ    64'h0000_0000_0000_8018
`define SDC_READY   64'h0000_0000_0000_8020
`define SDC_AVAIL   64'h0000_0000_0000_8028

// sd sector buffer window, one byte per address
`define SDC_BASE    64'h0000_0000_0000_9000
`define SDC_BYTES   512

// byte lanes making up one RAM word
`define LANES       4

`endif

// File: common/soc_pkg.sv
package soc_pkg;

    // bus side widths
    typedef logic [63:0] addr_t;
    typedef logic [63:0] dword_t;

    // RAM side widths
    typedef logic [31:0] word_t;
    typedef logic [7:0]  byte_t;
    typedef logic [9:0]  lane_addr_t;

    // [1:0] gives the size as byte, half, word or double
    // [2] marks an unsigned load
    typedef logic [2:0]  mem_op_t;

    typedef struct packed {
        addr_t   addr;
        dword_t  wdata;
        logic    rd;
        logic    wr;
        mem_op_t op;
    } bus_req_t;

    // one write port of a byte lane
    typedef struct packed {
        logic       we;
        lane_addr_t index;
        byte_t      data;
    } lane_wr_t;

    typedef enum logic {store_idle, store_high_beat} store_state_e;
    typedef enum logic [1:0] {load_idle, load_low_beat, load_high_beat, load_finish} load_state_e;
    typedef enum logic [1:0] {sd_st_idle, sd_st_filling, sd_st_full} sd_state_e;

endpackage

// File: memory/store_lane_steer.sv
`timescale 1ns/1ps
`include "soc_defs.svh"

module store_lane_steer (
    input  logic                           clock_1hz,
    input  logic                           KEY0,
    input  logic                           ram_store,
    input  soc_pkg::bus_req_t              bus_req,
    output soc_pkg::lane_wr_t [`LANES-1:0] lane_wr
);

    soc_pkg::store_state_e state;
    soc_pkg::addr_t        ram_off;
    soc_pkg::lane_addr_t   base_index;
    soc_pkg::lane_addr_t   hi_index;
    soc_pkg::word_t        hi_word;
    soc_pkg::word_t        lo_shifted;
    logic [`LANES-1:0]     lo_mask;
    logic                  is_double;

    // word index inside the RAM window
    assign ram_off    = bus_req.addr - `RAM_BASE;
    assign base_index = ram_off[11:2];
    assign is_double  = (bus_req.op[1:0] == 2'd3);

    // move store data up to its starting lane
    assign lo_shifted = bus_req.wdata[31:0] << {bus_req.addr[1:0], 3'b000};

    // lanes covered by the store size
    always_comb begin
        case (bus_req.op[1:0])
            2'd0:    lo_mask = 4'b0001 << bus_req.addr[1:0];
            2'd1:    lo_mask = 4'b0011 << bus_req.addr[1:0];
            default: lo_mask = 4'b1111;
        endcase
    end

    // high beat of sd owns all lanes for one cycle
    always_comb begin
        for (int k = 0; k < `LANES; k++) begin
            if (state == soc_pkg::store_high_beat) begin
                lane_wr[k].we    = 1'b1;
                lane_wr[k].index = hi_index;
                lane_wr[k].data  = hi_word[8*k +: 8];
            end else begin
                lane_wr[k].we    = ram_store & lo_mask[k];
                lane_wr[k].index = base_index;
                lane_wr[k].data  = lo_shifted[8*k +: 8];
            end
        end
    end

    always_ff @(posedge clock_1hz or negedge KEY0) begin
        if (!KEY0) begin
            state <= soc_pkg::store_idle;
        end else if (state == soc_pkg::store_high_beat) begin
            state <= soc_pkg::store_idle;
        end else if (ram_store && is_double) begin
            state <= soc_pkg::store_high_beat;
        end
    end

    // upper word and its index, written on the next cycle
    always_ff @(posedge clock_1hz) begin
        if (ram_store && is_double) begin
            hi_word  <= bus_req.wdata[63:32];
            hi_index <= base_index + 10'd1;
        end
    end

endmodule

// File: memory/ram_lane.sv
`timescale 1ns/1ps
`include "soc_defs.svh"

module ram_lane (
    input  logic                clock_1hz,
    input  soc_pkg::lane_wr_t   lane_wr,
    input  soc_pkg::lane_addr_t rd_index,
    output soc_pkg::byte_t      rd_byte
);

    // one byte of every RAM word
    soc_pkg::byte_t mem [`RAM_WORDS];

    always_ff @(posedge clock_1hz) begin
        if (lane_wr.we) begin
            mem[lane_wr.index] <= lane_wr.data;
        end
        // registered read, old data on a same-cycle write
        rd_byte <= mem[rd_index];
    end

endmodule

// File: memory/load_align.sv
`timescale 1ns/1ps
`include "soc_defs.svh"

module load_align (
    input  logic                        clock_1hz,
    input  logic                        KEY0,
    input  logic                        ram_load,
    input  soc_pkg::bus_req_t           bus_req,
    input  soc_pkg::byte_t [`LANES-1:0] lane_bytes,
    output soc_pkg::lane_addr_t         rd_index,
    output soc_pkg::dword_t             ram_result,
    output logic                        ram_done
);

    soc_pkg::load_state_e state;
    soc_pkg::addr_t       ram_off;
    soc_pkg::lane_addr_t  base_index;
    soc_pkg::word_t       lane_word;
    soc_pkg::word_t       lo_word;
    soc_pkg::word_t       shifted;
    logic                 sign_ext;

    // address and op stay held until the read completes
    assign ram_off    = bus_req.addr - `RAM_BASE;
    assign base_index = ram_off[11:2];
    assign rd_index   = (state == soc_pkg::load_high_beat) ? base_index + 10'd1 : base_index;

    // lane 0 is the least significant byte
    assign lane_word = lane_bytes;
    assign shifted   = lane_word >> {bus_req.addr[1:0], 3'b000};
    assign sign_ext  = ~bus_req.op[2];
    assign ram_done  = (state == soc_pkg::load_finish);

    always_comb begin
        case (bus_req.op[1:0])
            2'd0:    ram_result = {{56{shifted[7] & sign_ext}}, shifted[7:0]};
            2'd1:    ram_result = {{48{shifted[15] & sign_ext}}, shifted[15:0]};
            2'd2:    ram_result = {{32{shifted[31] & sign_ext}}, shifted};
            default: ram_result = {lane_word, lo_word};
        endcase
    end

    // low beat reads the word, ld adds a second read of the next index
    always_ff @(posedge clock_1hz or negedge KEY0) begin
        if (!KEY0) begin
            state <= soc_pkg::load_idle;
        end else begin
            case (state)
                soc_pkg::load_idle: begin
                    if (ram_load) begin
                        state <= soc_pkg::load_low_beat;
                    end
                end
                soc_pkg::load_low_beat: begin
                    if (bus_req.op[1:0] == 2'd3) begin
                        state <= soc_pkg::load_high_beat;
                    end else begin
                        state <= soc_pkg::load_finish;
                    end
                end
                soc_pkg::load_high_beat: state <= soc_pkg::load_finish;
                default:                 state <= soc_pkg::load_idle;
            endcase
        end
    end

    // low half of ld, lanes show it during the high beat
    always_ff @(posedge clock_1hz) begin
        if (state == soc_pkg::load_high_beat) begin
            lo_word <= lane_word;
        end
    end

endmodule

// File: rtl/sd_sector_buffer.sv
`timescale 1ns/1ps
`include "soc_defs.svh"

module sd_sector_buffer (
    input  logic           clock_1hz,
    input  logic           KEY0,
    input  logic           sd_write_addr,
    input  logic           sd_start,
    input  soc_pkg::word_t wdata,
    input  logic [8:0]     sd_read_index,
    output soc_pkg::byte_t sd_byte,
    output logic           sd_full,
    input  soc_pkg::byte_t sd_dout,
    input  logic           sd_byte_available,
    output logic           sd_rd_start,
    output soc_pkg::word_t sd_addr
);

    soc_pkg::sd_state_e state;
    soc_pkg::byte_t     sector [`SDC_BYTES];
    logic [9:0]         count;
    logic               avail_d;
    logic               byte_edge;
    logic               capture;

    // rising edge of the controller's byte strobe
    assign byte_edge = sd_byte_available && !avail_d;
    assign capture   = (state == soc_pkg::sd_st_filling) && byte_edge
                       && (count < 10'(`SDC_BYTES));

    // controller keeps reading while filling
    assign sd_rd_start = (state == soc_pkg::sd_st_filling);
    assign sd_full     = (state == soc_pkg::sd_st_full);
    assign sd_byte     = sector[sd_read_index];

    always_ff @(posedge clock_1hz or negedge KEY0) begin
        if (!KEY0) begin
            state   <= soc_pkg::sd_st_idle;
            count   <= '0;
            avail_d <= 1'b0;
            sd_addr <= '0;
        end else begin
            avail_d <= sd_byte_available;
            if (sd_write_addr) begin
                sd_addr <= wdata;
            end
            // a new start restarts the sector from any state
            if (sd_start) begin
                state <= soc_pkg::sd_st_filling;
                count <= '0;
            end else if (state == soc_pkg::sd_st_filling) begin
                if (count == 10'(`SDC_BYTES)) begin
                    state <= soc_pkg::sd_st_full;
                end else if (capture) begin
                    count <= count + 10'd1;
                end
            end
        end
    end

    always_ff @(posedge clock_1hz) begin
        if (capture) begin
            sector[count[8:0]] <= sd_dout;
        end
    end

endmodule

// File: rtl/mmio_ctrl.sv
`timescale 1ns/1ps
`include "soc_defs.svh"

module mmio_ctrl (
    input  logic              clock_1hz,
    input  logic              KEY0,
    input  soc_pkg::bus_req_t bus_req,
    output soc_pkg::dword_t   bus_read_data,
    output logic              bus_read_done,
    output logic              ram_store,
    output logic              ram_load,
    input  soc_pkg::dword_t   ram_result,
    input  logic              ram_done,
    output logic              sd_write_addr,
    output logic              sd_start,
    output logic [8:0]        sd_read_index,
    input  soc_pkg::byte_t    sd_byte,
    input  logic              sd_full,
    input  logic              sd_ready,
    input  soc_pkg::byte_t    key_ascii,
    input  logic              key_pressed,
    input  logic              irq_ack,
    output logic [3:0]        irq_vector,
    output logic              uart_write,
    output soc_pkg::byte_t    uart_data
);

    soc_pkg::addr_t  sdc_off;
    soc_pkg::dword_t periph_data;
    logic            ram_sel;
    logic            sdc_win_sel;
    logic            key_sel;
    logic            uart_sel;
    logic            key_pressed_d;
    logic            key_edge;

    // address windows
    assign ram_sel     = (bus_req.addr >= `RAM_BASE) && (bus_req.addr < `RAM_BASE + 4 * `RAM_WORDS);
    assign sdc_win_sel = (bus_req.addr >= `SDC_BASE) && (bus_req.addr < `SDC_BASE + `SDC_BYTES);
    assign key_sel     = (bus_req.addr == `KEY_ADDR);
    assign uart_sel    = (bus_req.addr == `UART_ADDR);

    // strobes routed to the blocks behind the decoder
    assign ram_store     = bus_req.wr && ram_sel;
    assign ram_load      = bus_req.rd && ram_sel;
    assign sd_write_addr = bus_req.wr && (bus_req.addr == `SDC_ADDR);
    assign sd_start      = bus_req.wr && (bus_req.addr == `SDC_READ);
    assign sdc_off       = bus_req.addr - `SDC_BASE;
    assign sd_read_index = sdc_off[8:0];

    // unmapped reads fall through to zero
    always_comb begin
        periph_data = '0;
        if (key_sel) begin
            periph_data = {56'd0, key_ascii};
        end else if (bus_req.addr == `SDC_READY) begin
            periph_data = {63'd0, sd_ready};
        end else if (bus_req.addr == `SDC_AVAIL) begin
            periph_data = {63'd0, sd_full};
        end else if (sdc_win_sel) begin
            periph_data = {56'd0, sd_byte};
        end
    end

    // done drops on the strobe, rises with the data
    always_ff @(posedge clock_1hz or negedge KEY0) begin
        if (!KEY0) begin
            bus_read_done <= 1'b1;
            bus_read_data <= '0;
        end else if (bus_req.rd) begin
            bus_read_done <= 1'b0;
        end else if (!bus_read_done) begin
            if (!ram_sel) begin
                bus_read_data <= periph_data;
                bus_read_done <= 1'b1;
            end else if (ram_done) begin
                bus_read_data <= ram_result;
                bus_read_done <= 1'b1;
            end
        end
    end

    // key press edge with a printable code raises vector 1
    assign key_edge = key_pressed && !key_pressed_d;

    always_ff @(posedge clock_1hz or negedge KEY0) begin
        if (!KEY0) begin
            key_pressed_d <= 1'b0;
            irq_vector    <= 4'd0;
            uart_write    <= 1'b0;
        end else begin
            key_pressed_d <= key_pressed;
            if (key_edge && (key_ascii != 8'd0)) begin
                irq_vector <= 4'd1;
            end
            // ack wins over a press in the same cycle
            if (irq_ack) begin
                irq_vector <= 4'd0;
            end
            uart_write <= bus_req.wr && uart_sel;
        end
    end

    // character held for the uart pulse
    always_ff @(posedge clock_1hz) begin
        if (bus_req.wr && uart_sel) begin
            uart_data <= bus_req.wdata[7:0];
        end
    end

endmodule

// File: rtl/soc_bus_top.sv
`timescale 1ns/1ps
`include "soc_defs.svh"

module soc_bus_top (
    input  logic              clock_1hz,
    input  logic              KEY0,
    input  soc_pkg::bus_req_t bus_req,
    output soc_pkg::dword_t   bus_read_data,
    output logic              bus_read_done,
    input  soc_pkg::byte_t    key_ascii,
    input  logic              key_pressed,
    input  logic              irq_ack,
    output logic [3:0]        irq_vector,
    output logic              uart_write,
    output soc_pkg::byte_t    uart_data,
    input  soc_pkg::byte_t    sd_dout,
    input  logic              sd_byte_available,
    input  logic              sd_ready,
    output logic              sd_rd_start,
    output soc_pkg::word_t    sd_addr
);

    soc_pkg::lane_wr_t [`LANES-1:0] lane_wr;
    soc_pkg::byte_t [`LANES-1:0]    lane_bytes;
    soc_pkg::lane_addr_t            rd_index;
    soc_pkg::dword_t                ram_result;
    soc_pkg::byte_t                 sd_byte;
    logic [8:0]                     sd_read_index;
    logic                           ram_store;
    logic                           ram_load;
    logic                           ram_done;
    logic                           sd_write_addr;
    logic                           sd_start;
    logic                           sd_full;

    mmio_ctrl u_mmio_ctrl (
        .clock_1hz     (clock_1hz),
        .KEY0          (KEY0),
        .bus_req       (bus_req),
        .bus_read_data (bus_read_data),
        .bus_read_done (bus_read_done),
        .ram_store     (ram_store),
        .ram_load      (ram_load),
        .ram_result    (ram_result),
        .ram_done      (ram_done),
        .sd_write_addr (sd_write_addr),
        .sd_start      (sd_start),
        .sd_read_index (sd_read_index),
        .sd_byte       (sd_byte),
        .sd_full       (sd_full),
        .sd_ready      (sd_ready),
        .key_ascii     (key_ascii),
        .key_pressed   (key_pressed),
        .irq_ack       (irq_ack),
        .irq_vector    (irq_vector),
        .uart_write    (uart_write),
        .uart_data     (uart_data)
    );

    store_lane_steer u_store_lane_steer (
        .clock_1hz (clock_1hz),
        .KEY0      (KEY0),
        .ram_store (ram_store),
        .bus_req   (bus_req),
        .lane_wr   (lane_wr)
    );

    // one bank per byte of the RAM word, shared read index
    for (genvar g = 0; g < `LANES; g++) begin : g_lane
        ram_lane u_ram_lane (
            .clock_1hz (clock_1hz),
            .lane_wr   (lane_wr[g]),
            .rd_index  (rd_index),
            .rd_byte   (lane_bytes[g])
        );
    end

    load_align u_load_align (
        .clock_1hz  (clock_1hz),
        .KEY0       (KEY0),
        .ram_load   (ram_load),
        .bus_req    (bus_req),
        .lane_bytes (lane_bytes),
        .rd_index   (rd_index),
        .ram_result (ram_result),
        .ram_done   (ram_done)
    );

    sd_sector_buffer u_sd_sector_buffer (
        .clock_1hz         (clock_1hz),
        .KEY0              (KEY0),
        .sd_write_addr     (sd_write_addr),
        .sd_start          (sd_start),
        .wdata             (bus_req.wdata[31:0]),
        .sd_read_index     (sd_read_index),
        .sd_byte           (sd_byte),
        .sd_full           (sd_full),
        .sd_dout           (sd_dout),
        .sd_byte_available (sd_byte_available),
        .sd_rd_start       (sd_rd_start),
        .sd_addr           (sd_addr)
    );

endmodule

// File: tb/tb_soc_bus.sv
`timescale 1ns/1ps
`include "soc_defs.svh"

module tb_soc_bus;

    localparam int CLK_PERIOD = 100;
    // RAM byte offsets of the sub-word and doubleword test regions
    localparam int REG_OFF    = 'h200;
    localparam int DBL_OFF    = 'h400;
    localparam int N_FILL     = 32;
    localparam int N_SUB      = 40;
    localparam int N_LOAD     = 48;
    localparam int N_DBL      = 8;
    localparam int N_DBL_SUB  = 16;
    localparam int N_MISC     = 40;
    // sd bytes sent plus sd window reads
    localparam int NUM_OPS    = N_FILL + N_SUB + N_LOAD + 2 * N_DBL + N_DBL_SUB
                                + N_MISC + 2 * `SDC_BYTES;

    logic                clock_1hz;
    logic                KEY0;
    soc_pkg::bus_req_t   bus_req;
    soc_pkg::dword_t     bus_read_data;
    logic                bus_read_done;
    soc_pkg::byte_t      key_ascii;
    logic                key_pressed;
    logic                irq_ack;
    logic [3:0]          irq_vector;
    logic                uart_write;
    soc_pkg::byte_t      uart_data;
    soc_pkg::byte_t      sd_dout;
    logic                sd_byte_available;
    logic                sd_ready;
    logic                sd_rd_start;
    soc_pkg::word_t      sd_addr;

    integer              seed = 29;
    // reference RAM image and bytes handed to the sd buffer
    soc_pkg::byte_t      ram_model [4 * `RAM_WORDS];
    soc_pkg::byte_t      sd_bytes [`SDC_BYTES];
    int                  sd_sent;
    // expected read results in issue order
    soc_pkg::dword_t     exp_q [$];
    string               name_q [$];
    logic                prev_done;
    logic                done_rose;

    soc_pkg::mem_op_t    load_ops [6] = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5, 3'd6};
    soc_pkg::addr_t      unmapped [6] = '{64'h0, 64'h0ffc, 64'h2000, 64'h8030,
                                          64'h9200, 64'hffff_0000_0000_1000};

    soc_bus_top DUT (
        .clock_1hz         (clock_1hz),
        .KEY0              (KEY0),
        .bus_req           (bus_req),
        .bus_read_data     (bus_read_data),
        .bus_read_done     (bus_read_done),
        .key_ascii         (key_ascii),
        .key_pressed       (key_pressed),
        .irq_ack           (irq_ack),
        .irq_vector        (irq_vector),
        .uart_write        (uart_write),
        .uart_data         (uart_data),
        .sd_dout           (sd_dout),
        .sd_byte_available (sd_byte_available),
        .sd_ready          (sd_ready),
        .sd_rd_start       (sd_rd_start),
        .sd_addr           (sd_addr)
    );

    initial clock_1hz = 1'b0;
    always #(CLK_PERIOD / 2) clock_1hz = ~clock_1hz;

    task automatic stop_on_failure(string why);
        $display("** FAIL **");
        $fatal(1, "%s", why);
    endtask

    task automatic check_dword(string name, soc_pkg::dword_t got, soc_pkg::dword_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
            stop_on_failure({"value mismatch on ", name});
        end
    endtask

    task automatic check_byte(string name, soc_pkg::byte_t got, soc_pkg::byte_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
            stop_on_failure({"value mismatch on ", name});
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
            stop_on_failure({"value mismatch on ", name});
        end
    endtask

    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    // little endian gather, then sign fill above the loaded size
    function automatic soc_pkg::dword_t load_ref(int off, soc_pkg::mem_op_t op);
        int              nbytes;
        soc_pkg::dword_t v;
        nbytes = 1 << op[1:0];
        v = '0;
        for (int i = 0; i < nbytes; i++) begin
            v[8*i +: 8] = ram_model[off + i];
        end
        if (!op[2] && nbytes < 8 && v[8*nbytes-1]) begin
            v = v | (~64'd0 << (8 * nbytes));
        end
        return v;
    endfunction

    // all driving happens just after the rising edge
    task automatic next_cycle();
        @(posedge clock_1hz);
        #1;
    endtask

    task automatic write_bus(soc_pkg::addr_t addr, soc_pkg::mem_op_t op, soc_pkg::dword_t data);
        bus_req.addr  = addr;
        bus_req.op    = op;
        bus_req.wdata = data;
        bus_req.wr    = 1'b1;
        next_cycle();
        bus_req.wr = 1'b0;
        // high word of a double store still going in
        if (op[1:0] == 2'd3) begin
            next_cycle();
        end
    endtask

    task automatic store_ram(int off, soc_pkg::mem_op_t op, soc_pkg::dword_t data);
        write_bus(`RAM_BASE + 64'(off), op, data);
        for (int i = 0; i < (1 << op[1:0]); i++) begin
            ram_model[off + i] = data[8*i +: 8];
        end
    endtask

    // queue the expectation, strobe, then hold until done returns
    task automatic read_expect(soc_pkg::addr_t addr, soc_pkg::mem_op_t op,
                               soc_pkg::dword_t exp);
        exp_q.push_back(exp);
        name_q.push_back($sformatf("bus_read_data @%h", addr));
        bus_req.addr = addr;
        bus_req.op   = op;
        bus_req.rd   = 1'b1;
        next_cycle();
        bus_req.rd = 1'b0;
        while (bus_read_done !== 1'b1) begin
            @(negedge clock_1hz);
        end
        next_cycle();
    endtask

    // stands in for the sd controller with one byte every two cycles
    task automatic send_sector();
        logic [31:0] r;
        for (int i = 0; i < `SDC_BYTES; i++) begin
            r = rand32();
            sd_bytes[i]       = r[7:0];
            sd_dout           = r[7:0];
            sd_byte_available = 1'b1;
            @(posedge clock_1hz);
            sd_sent = sd_sent + 1;
            #1;
            sd_byte_available = 1'b0;
            next_cycle();
        end
    endtask

    // compare at the negedge after done rises
    always @(negedge clock_1hz) begin
        done_rose = (prev_done === 1'b0) && (bus_read_done === 1'b1);
        prev_done = bus_read_done;
        if (KEY0 && done_rose) begin
            if (exp_q.size() == 0) begin
                stop_on_failure("a read completed with no expected value queued");
            end else begin
                check_dword(name_q.pop_front(), bus_read_data, exp_q.pop_front());
            end
        end
    end

    initial begin
        #(NUM_OPS * 20 * CLK_PERIOD);
        stop_on_failure($sformatf("timeout, tests did not finish within %0d cycles",
                                  NUM_OPS * 20));
    end

    initial begin
        int               off;
        int               sz;
        logic [31:0]      r;
        soc_pkg::mem_op_t op;
        soc_pkg::dword_t  d;
        soc_pkg::byte_t   c;
        KEY0              = 1'b0;
        bus_req           = '0;
        key_ascii         = '0;
        key_pressed       = 1'b0;
        irq_ack           = 1'b0;
        sd_dout           = '0;
        sd_byte_available = 1'b0;
        sd_ready          = 1'b0;
        sd_sent           = 0;
        repeat (3) @(posedge clock_1hz);
        #1;
        KEY0 = 1'b1;

        // reset values
        check_bit("bus_read_done", bus_read_done, 1'b1);
        check_byte("irq_vector", {4'd0, irq_vector}, 8'd0);
        check_bit("uart_write", uart_write, 1'b0);
        check_bit("sd_rd_start", sd_rd_start, 1'b0);
        next_cycle();

        // word fill so every tested byte is known
        for (int i = 0; i < N_FILL; i++) begin
            store_ram(REG_OFF + 4 * i, 3'd2, {32'd0, rand32()});
        end
        for (int i = 0; i < N_SUB; i++) begin
            op = soc_pkg::mem_op_t'(i % 3);
            sz = int'(op[1:0]);
            r = rand32();
            off = REG_OFF + (int'(r[6:0]) & ~((1 << sz) - 1));
            store_ram(off, op, {32'd0, rand32()});
        end
        // cycle through lb lh lw lbu lhu lwu
        for (int i = 0; i < N_LOAD; i++) begin
            op = load_ops[i % 6];
            sz = int'(op[1:0]);
            r = rand32();
            off = REG_OFF + (int'(r[6:0]) & ~((1 << sz) - 1));
            read_expect(`RAM_BASE + 64'(off), op, load_ref(off, op));
        end

        // doublewords, then ld and sub-word reads inside them
        for (int i = 0; i < N_DBL; i++) begin
            d[63:32] = rand32();
            d[31:0]  = rand32();
            store_ram(DBL_OFF + 8 * i, 3'd3, d);
        end
        for (int i = 0; i < N_DBL; i++) begin
            read_expect(`RAM_BASE + 64'(DBL_OFF + 8 * i), 3'd3, load_ref(DBL_OFF + 8 * i, 3'd3));
        end
        for (int i = 0; i < N_DBL_SUB; i++) begin
            op = load_ops[i % 6];
            sz = int'(op[1:0]);
            r = rand32();
            off = DBL_OFF + (int'(r[5:0]) & ~((1 << sz) - 1));
            read_expect(`RAM_BASE + 64'(off), op, load_ref(off, op));
        end

        // keyboard press with a printable code
        r = rand32();
        c = (r[7:0] == 8'd0) ? 8'h5a : r[7:0];
        key_ascii   = c;
        key_pressed = 1'b1;
        next_cycle();
        check_byte("irq_vector", {4'd0, irq_vector}, 8'd1);
        read_expect(`KEY_ADDR, 3'd3, {56'd0, c});
        key_pressed = 1'b0;
        irq_ack     = 1'b1;
        next_cycle();
        irq_ack = 1'b0;
        check_byte("irq_vector", {4'd0, irq_vector}, 8'd0);
        // zero code raises nothing
        key_ascii = 8'd0;
        next_cycle();
        key_pressed = 1'b1;
        next_cycle();
        next_cycle();
        check_byte("irq_vector", {4'd0, irq_vector}, 8'd0);
        key_pressed = 1'b0;

        // uart pulse is one cycle wide
        for (int i = 0; i < 4; i++) begin
            r = rand32();
            write_bus(`UART_ADDR, 3'd0, {32'd0, r});
            check_bit("uart_write", uart_write, 1'b1);
            check_byte("uart_data", uart_data, r[7:0]);
            next_cycle();
            check_bit("uart_write", uart_write, 1'b0);
        end

        // sd ready follows the input
        sd_ready = 1'b0;
        read_expect(`SDC_READY, 3'd3, 64'd0);
        sd_ready = 1'b1;
        read_expect(`SDC_READY, 3'd3, 64'd1);
        r = rand32();
        write_bus(`SDC_ADDR, 3'd2, {32'd0, r});
        check_dword("sd_addr", {32'd0, sd_addr}, {32'd0, r});
        write_bus(`SDC_READ, 3'd2, 64'd1);
        check_bit("sd_rd_start", sd_rd_start, 1'b1);
        fork
            send_sector();
        join_none
        // not available while bytes are still arriving
        while (sd_sent < `SDC_BYTES) begin
            read_expect(`SDC_AVAIL, 3'd3, 64'd0);
        end
        read_expect(`SDC_AVAIL, 3'd3, 64'd1);
        check_bit("sd_rd_start", sd_rd_start, 1'b0);
        for (int i = 0; i < `SDC_BYTES; i++) begin
            read_expect(`SDC_BASE + 64'(i), 3'd4, {56'd0, sd_bytes[i]});
        end

        // each unmapped read follows a read that leaves nonzero data behind
        for (int i = 0; i < 6; i++) begin
            read_expect(`SDC_AVAIL, 3'd3, 64'd1);
            read_expect(unmapped[i], 3'd3, 64'd0);
        end

        next_cycle();
        if (exp_q.size() != 0) begin
            stop_on_failure("reads were issued but never completed");
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

// File: build.f
+incdir+common
common/soc_pkg.sv
memory/store_lane_steer.sv
memory/ram_lane.sv
memory/load_align.sv
rtl/sd_sector_buffer.sv
rtl/mmio_ctrl.sv
rtl/soc_bus_top.sv
tb/tb_soc_bus.sv

// File: Makefile
# Verilator build of the bus subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_soc_bus
OBJ_DIR   ?= obj_dir
FILELIST  ?= build.f
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0

SRCS := $(wildcard common/*.sv common/*.svh memory/*.sv rtl/*.sv tb/*.sv)
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP)

# exit status of the simulator is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
